/* source/cop_pkg.sv */
/* Shared constants and types for the COP watchdog. Full 16-bit word accesses only,
   no byte lanes. Counter and bus share bus_clk. */

`default_nettype none

package cop_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int DATA_W  = 16;                  // Wishbone data width
  localparam int ADDR_W  = 2;                   // Register address width
  localparam int COUNT_W = 16;                  // Timeout counter width

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [ADDR_W-1:0] ADDR_CTRL    = 2'd0;  // Control and status
  localparam logic [ADDR_W-1:0] ADDR_TIMEOUT = 2'd1;  // Reload value
  localparam logic [ADDR_W-1:0] ADDR_SERVICE = 2'd2;  // Service writes, counter reads

  // ------------------------------
  // Reset and service values
  // ------------------------------
  localparam logic               INIT_ENA    = 1'b1;               // Watchdog on after reset
  localparam logic [COUNT_W-1:0] TIMEOUT_RST = {COUNT_W{1'b1}};    // Longest timeout
  localparam logic [DATA_W-1:0]  SERV_WD_0   = 16'h5555;           // Arms the reload
  localparam logic [DATA_W-1:0]  SERV_WD_1   = 16'hAAAA;           // Completes the reload

  // Interrupt levels, selected by irq_en 1..3
  localparam logic [COUNT_W-1:0] IRQ_THR_1 = 16'd16;
  localparam logic [COUNT_W-1:0] IRQ_THR_2 = 16'd32;
  localparam logic [COUNT_W-1:0] IRQ_THR_3 = 16'd64;

  // ------------------------------
  // Control word layout
  // ------------------------------
  // Declared MSB first, so clck lands in bit 0
  typedef struct packed {
    logic [6:0] spare;          // Read as zero
    logic       clear_event;    // Write 1 to clear event, reads back event bit
    logic [1:0] irq_en;         // Threshold select, 0 is off
    logic       debug_ena;      // Halt count in debug mode
    logic       stop_ena;       // Halt count in stop mode
    logic       wait_ena;       // Halt count in wait mode
    logic       ena;            // Watchdog enable
    logic       cwp;            // Write protect on ena
    logic       clck;           // Sticky lock on cwp
  } ctrl_fields_t;

  // One bus word seen either as control fields or as a plain value
  typedef union packed {
    ctrl_fields_t        ctrl;  // Control register view
    logic [DATA_W-1:0]   raw;   // Timeout and service view
  } cop_wdata_u;

endpackage

`default_nettype wire

/* source/cop_ifs.sv */
/* Internal links of the COP watchdog. Strobes and pulses are one bus_clk cycle wide,
   with no handshake. */

`timescale 1ns/1ps
`default_nettype none

// Write strobes from the bus port into the register bank
interface cop_wr_if;
  logic                   wr_ctrl;      // Control word write
  logic                   wr_timeout;   // Timeout word write
  logic                   wr_service;   // Service word write
  cop_pkg::cop_wdata_u    wdata;        // Write data, two views

  modport bus_mp  (output wr_ctrl, wr_timeout, wr_service, wdata);
  modport regs_mp (input  wr_ctrl, wr_timeout, wr_service, wdata);
endinterface

// Register fields and command pulses out of the register bank
interface cop_cfg_if;
  logic [cop_pkg::COUNT_W-1:0] timeout_value;  // Reload value
  logic [1:0]                  irq_en;         // Threshold select
  logic                        debug_ena, stop_ena, wait_ena;
  logic                        cop_ena;        // Counter running
  logic                        cwp, clck;      // Protection bits
  logic                        reload_pulse;   // Good service sequence seen
  logic                        clear_pulse;    // Event clear request

  modport regs_mp  (output timeout_value, irq_en, debug_ena, stop_ena, wait_ena,
                    cop_ena, cwp, clck, reload_pulse, clear_pulse);
  modport timer_mp (input timeout_value, irq_en, debug_ena, stop_ena, wait_ena,
                    cop_ena, reload_pulse, clear_pulse);
  modport view_mp  (input timeout_value, irq_en, debug_ena, stop_ena, wait_ena,
                    cop_ena, cwp, clck);
endinterface

`default_nettype wire

/* source/cop_bus_port.sv */
/* Wishbone slave with one fixed wait state, so every access takes two cycles.
   Word accesses only; read data is valid while wb_ack_o is high. */

`timescale 1ns/1ps
`default_nettype none

module cop_bus_port (
  input  logic                         bus_clk,
  input  logic                         async_rst_b,
  input  logic                         wb_cyc_i,      // Valid bus cycle
  input  logic                         wb_stb_i,      // Slave select
  input  logic                         wb_we_i,       // Write enable
  input  logic [cop_pkg::ADDR_W-1:0]   wb_adr_i,      // Word address
  input  logic [cop_pkg::DATA_W-1:0]   wb_dat_i,      // Write data
  output logic [cop_pkg::DATA_W-1:0]   wb_dat_o,      // Registered read data
  output logic                         wb_ack_o,      // Ack in second cycle
  cop_wr_if.bus_mp                     wr,            // Write strobes out
  cop_cfg_if.view_mp                   cfg,           // Fields for readback
  input  logic [cop_pkg::COUNT_W-1:0]  count_i,       // Live counter value
  input  logic                         event_i        // Sticky event bit
);

  logic                        module_sel;    // cyc and stb together
  logic                        bus_wait_state; // High in the ack cycle
  logic                        wb_wacc;       // Write in ack cycle
  logic                        wb_racc;       // Read in first cycle
  cop_pkg::ctrl_fields_t       rd_ctrl;       // Control readback word
  logic [cop_pkg::DATA_W-1:0]  rd_data_mux;   // Unregistered read value

  assign module_sel = wb_cyc_i && wb_stb_i;
  assign wb_ack_o   = module_sel && bus_wait_state;
  assign wb_wacc    = wb_ack_o && wb_we_i;
  assign wb_racc    = module_sel && !wb_we_i && !bus_wait_state;

  // Wait state toggles, so back to back accesses still take two cycles each
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      bus_wait_state <= 1'b0;
    else
      bus_wait_state <= module_sel && !bus_wait_state;

  // ------------------------------
  // Write decode
  // ------------------------------
  assign wr.wr_ctrl    = wb_wacc && (wb_adr_i == cop_pkg::ADDR_CTRL);
  assign wr.wr_timeout = wb_wacc && (wb_adr_i == cop_pkg::ADDR_TIMEOUT);
  assign wr.wr_service = wb_wacc && (wb_adr_i == cop_pkg::ADDR_SERVICE);
  assign wr.wdata.raw  = wb_dat_i;               // Full word, no lanes

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb
  begin
    rd_ctrl             = '0;                    // Spare bits stay zero
    rd_ctrl.clck        = cfg.clck;
    rd_ctrl.cwp         = cfg.cwp;
    rd_ctrl.ena         = cfg.cop_ena;
    rd_ctrl.wait_ena    = cfg.wait_ena;
    rd_ctrl.stop_ena    = cfg.stop_ena;
    rd_ctrl.debug_ena   = cfg.debug_ena;
    rd_ctrl.irq_en      = cfg.irq_en;
    rd_ctrl.clear_event = event_i;               // Event shows in clear slot
    case (wb_adr_i)
      cop_pkg::ADDR_CTRL:    rd_data_mux = rd_ctrl;
      cop_pkg::ADDR_TIMEOUT: rd_data_mux = cfg.timeout_value;
      cop_pkg::ADDR_SERVICE: rd_data_mux = count_i;
      default:               rd_data_mux = '0;   // Unmapped address
    endcase
  end

  // Captured at the end of the first cycle, held through ack
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      wb_dat_o <= '0;
    else if (wb_racc)
      wb_dat_o <= rd_data_mux;

endmodule

`default_nettype wire

/* source/cop_ctrl_regs.sv */
/* Control and timeout registers with the lock rules. Timeout writes are dropped
   while the COP runs; reload needs 0x5555 then 0xAAAA as consecutive service writes. */

`timescale 1ns/1ps
`default_nettype none

module cop_ctrl_regs (
  input  logic        bus_clk,
  input  logic        async_rst_b,
  cop_wr_if.regs_mp   wr,             // Strobes from the bus port
  cop_cfg_if.regs_mp  cfg             // Fields and pulses to timer and readback
);

  cop_pkg::ctrl_fields_t  wf;         // Control view of the write word
  logic                   run_wr_ok;  // Run enables may change
  logic                   serv_armed; // Last service word was SERV_WD_0

  assign wf        = wr.wdata.ctrl;
  assign run_wr_ok = !cfg.cop_ena || !wf.ena;

  // ------------------------------
  // Control register
  // ------------------------------
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
    begin
      cfg.irq_en      <= 2'b00;
      cfg.debug_ena   <= 1'b0;
      cfg.stop_ena    <= 1'b0;
      cfg.wait_ena    <= 1'b0;
      cfg.cop_ena     <= cop_pkg::INIT_ENA;
      cfg.cwp         <= 1'b0;
      cfg.clck        <= 1'b0;
      cfg.clear_pulse <= 1'b0;
    end
    else
    begin
      cfg.clear_pulse <= wr.wr_ctrl && wf.clear_event;   // One cycle clear request
      if (wr.wr_ctrl)
      begin
        cfg.irq_en <= wf.irq_en;                         // Never protected
        if (run_wr_ok)
        begin
          cfg.debug_ena <= wf.debug_ena;
          cfg.stop_ena  <= wf.stop_ena;
          cfg.wait_ena  <= wf.wait_ena;
        end
        if (!cfg.cwp)
          cfg.cop_ena <= wf.ena;                         // Protected by cwp
        if (!cfg.clck)
          cfg.cwp <= wf.cwp;                             // Protected by clck
        cfg.clck <= cfg.clck || wf.clck;                 // Set only, until reset
      end
    end

  // ------------------------------
  // Timeout register
  // ------------------------------
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      cfg.timeout_value <= cop_pkg::TIMEOUT_RST;
    else if (wr.wr_timeout && !cfg.cop_ena)
      cfg.timeout_value <= wr.wdata.raw;                 // Only while stopped

  // ------------------------------
  // Service sequence
  // ------------------------------
  // Any service write re-arms or disarms; the second word must follow directly
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
    begin
      serv_armed       <= 1'b0;
      cfg.reload_pulse <= 1'b0;
    end
    else if (wr.wr_service)
    begin
      serv_armed       <= (wr.wdata.raw == cop_pkg::SERV_WD_0);
      cfg.reload_pulse <= serv_armed && (wr.wdata.raw == cop_pkg::SERV_WD_1);
    end
    else
      cfg.reload_pulse <= 1'b0;                          // Single cycle

endmodule

`default_nettype wire

/* source/cop_timer.sv */
/* Watchdog down counter on bus_clk. Holds at zero and keeps cop_rst_o high until
   a reload; loads the timeout every cycle while the COP is disabled. */

`timescale 1ns/1ps
`default_nettype none

module cop_timer (
  input  logic                         bus_clk,
  input  logic                         async_rst_b,
  cop_cfg_if.timer_mp                  cfg,           // Settings and pulses
  input  logic                         debug_mode_i,  // System debug mode
  input  logic                         wait_mode_i,   // System wait mode
  input  logic                         stop_mode_i,   // System stop mode
  output logic [cop_pkg::COUNT_W-1:0]  count_o,       // Counter value
  output logic                         event_o,       // Sticky expiry status
  output logic                         cop_rst_o,     // Expiry reset
  output logic                         cop_irq_o      // Near-expiry interrupt
);

  logic load;          // Reload from timeout_value
  logic stop_counter;  // A system mode halts the count
  logic at_zero;       // Counter expired
  logic irq_dec;       // Threshold reached
  logic event_reset;   // Clear the status bit

  assign load         = cfg.reload_pulse || !cfg.cop_ena;
  assign stop_counter = (debug_mode_i && cfg.debug_ena) ||
                        (wait_mode_i  && cfg.wait_ena)  ||
                        (stop_mode_i  && cfg.stop_ena);
  assign at_zero      = (count_o == '0);
  assign event_reset  = cfg.reload_pulse || cfg.clear_pulse;

  // ------------------------------
  // Counter and expiry
  // ------------------------------
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      count_o <= cop_pkg::TIMEOUT_RST;
    else if (load)
      count_o <= cfg.timeout_value;
    else if (!stop_counter && !at_zero)
      count_o <= count_o - 1'b1;                    // No wrap below zero

  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      cop_rst_o <= 1'b0;
    else if (load)
      cop_rst_o <= 1'b0;
    else
      cop_rst_o <= cop_rst_o || at_zero;            // Held until serviced

  // ------------------------------
  // Interrupt
  // ------------------------------
  always_comb
    case (cfg.irq_en)
      2'b01:   irq_dec = (count_o <= cop_pkg::IRQ_THR_1);
      2'b10:   irq_dec = (count_o <= cop_pkg::IRQ_THR_2);
      2'b11:   irq_dec = (count_o <= cop_pkg::IRQ_THR_3);
      default: irq_dec = 1'b0;                      // Interrupt off
    endcase

  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      cop_irq_o <= 1'b0;
    else
      cop_irq_o <= irq_dec;                         // One cycle behind count

  // Status bit follows cop_rst_o and holds until cleared
  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      event_o <= 1'b0;
    else
      event_o <= cop_rst_o || (event_o && !event_reset);

endmodule

`default_nettype wire

/* source/cop_top.sv */
/* COP watchdog top level. All logic runs on bus_clk with one active-low
   asynchronous reset. */

`timescale 1ns/1ps
`default_nettype none

module cop_top (
  input  logic                        bus_clk,
  input  logic                        async_rst_b,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [cop_pkg::ADDR_W-1:0]  wb_adr_i,
  input  logic [cop_pkg::DATA_W-1:0]  wb_dat_i,
  output logic [cop_pkg::DATA_W-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        debug_mode_i,
  input  logic                        wait_mode_i,
  input  logic                        stop_mode_i,
  output logic                        cop_rst_o,     // High on expiry
  output logic                        cop_irq_o      // High below threshold
);

  logic [cop_pkg::COUNT_W-1:0] count;       // Timer to readback
  logic                        cop_event;   // Timer to readback

  cop_wr_if  wr_if ();
  cop_cfg_if cfg_if ();

  // ------------------------------
  cop_bus_port u_bus_port (
    .bus_clk     (bus_clk),
    .async_rst_b (async_rst_b),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wr          (wr_if.bus_mp),
    .cfg         (cfg_if.view_mp),
    .count_i     (count),
    .event_i     (cop_event)
  );

  cop_ctrl_regs u_ctrl_regs (
    .bus_clk     (bus_clk),
    .async_rst_b (async_rst_b),
    .wr          (wr_if.regs_mp),
    .cfg         (cfg_if.regs_mp)
  );

  cop_timer u_timer (
    .bus_clk      (bus_clk),
    .async_rst_b  (async_rst_b),
    .cfg          (cfg_if.timer_mp),
    .debug_mode_i (debug_mode_i),
    .wait_mode_i  (wait_mode_i),
    .stop_mode_i  (stop_mode_i),
    .count_o      (count),
    .event_o      (cop_event),
    .cop_rst_o    (cop_rst_o),
    .cop_irq_o    (cop_irq_o)
  );

endmodule

`default_nettype wire

/* sim/cop_tb.sv */
/* Pattern-driven testbench, run from the project root so sim/cop_patterns.txt is found.
   Counter reads are exact only while the count is stopped or the COP is disabled. */

`timescale 1ns/1ps
`default_nettype none

module cop_tb;

  logic                        bus_clk;
  logic                        async_rst_b;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [cop_pkg::ADDR_W-1:0]  wb_adr_i;
  logic [cop_pkg::DATA_W-1:0]  wb_dat_i;
  logic [cop_pkg::DATA_W-1:0]  wb_dat_o;
  logic                        wb_ack_o;
  logic                        debug_mode_i;
  logic                        wait_mode_i;
  logic                        stop_mode_i;
  logic                        cop_rst_o;
  logic                        cop_irq_o;

  // Pattern table, one entry per file line
  logic [7:0]                  op_q[$];
  logic [cop_pkg::ADDR_W-1:0]  adr_q[$];
  logic [cop_pkg::DATA_W-1:0]  dat_q[$];
  logic [2:0]                  mode_q[$];       // debug, wait, stop
  logic [cop_pkg::DATA_W-1:0]  exp_q[$];

  int                          errors = 0;
  int                          checks = 0;
  int                          cycles = 0;
  int                          limit  = 0;      // Set once patterns are loaded
  logic [cop_pkg::DATA_W-1:0]  rdata;           // Data seen in the ack cycle
  cop_pkg::cop_wdata_u         exp_w;           // Expected word, ctrl view for reads

  cop_top UUT (.*);

  initial
  begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;             // 100 ns period
  end

  // ------------------------------
  // Run limit
  // ------------------------------
  initial
  begin
    wait (limit > 0);
    while (cycles < limit)
    begin
      @(posedge bus_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Whole file first, so the limit is known before the first edge
  task automatic load_patterns;
    int                          fd;
    int                          rc;
    int                          idle_sum;
    string                       line;
    logic [7:0]                  op;
    logic [cop_pkg::ADDR_W-1:0]  adr;
    logic [cop_pkg::DATA_W-1:0]  dat;
    logic [2:0]                  mode;
    logic [cop_pkg::DATA_W-1:0]  exp_v;
    idle_sum = 0;
    fd = $fopen("sim/cop_patterns.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open sim/cop_patterns.txt, so no stimulus was applied");
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != "#")             // Skip blanks and column notes
        begin
          rc = $sscanf(line, "%c %h %h %h %h", op, adr, dat, mode, exp_v);
          if (rc == 5)
          begin
            op_q.push_back(op);
            adr_q.push_back(adr);
            dat_q.push_back(dat);
            mode_q.push_back(mode);
            exp_q.push_back(exp_v);
            if (op == "I")
              idle_sum += dat;                    // Idle count in data column
          end
        end
      end
      $fclose(fd);
    end
    if (op_q.size() == 0)
    begin
      errors++;
      $display("The pattern file held no operations");
    end
    limit = 6 * op_q.size() + idle_sum + 50;
  endtask

  // ------------------------------
  // Bus and checks
  // ------------------------------
  // Called on a falling edge; returns after the strobe is dropped
  task automatic bus_access(input logic we, input logic [cop_pkg::ADDR_W-1:0] adr,
                            input logic [cop_pkg::DATA_W-1:0] dat,
                            output logic [cop_pkg::DATA_W-1:0] data_seen);
    int waits;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    waits    = 0;
    do
    begin
      @(negedge bus_clk);
      waits++;
    end
    while (!wb_ack_o && waits < 8);
    data_seen = wb_dat_o;                         // Valid while ack is high
    if (!wb_ack_o)
    begin
      errors++;
      $display("No acknowledge from the DUT for an access to address %0d", adr);
    end
    @(negedge bus_clk);                           // Rising edge in between commits the write
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [cop_pkg::DATA_W-1:0] expected,
                             input logic [cop_pkg::DATA_W-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  initial
  begin
    void'($urandom(23));                          // Seed for the idle gaps
    async_rst_b  = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    debug_mode_i = 1'b0;
    wait_mode_i  = 1'b0;
    stop_mode_i  = 1'b0;
    load_patterns();
    repeat (8) @(negedge bus_clk);
    async_rst_b = 1'b1;

    for (int i = 0; i < op_q.size(); i++)
    begin
      repeat ($urandom % 4) @(negedge bus_clk);   // Random gap of 0 to 3 cycles
      @(negedge bus_clk);
      {debug_mode_i, wait_mode_i, stop_mode_i} = mode_q[i];
      case (op_q[i])
        "W": bus_access(1'b1, adr_q[i], dat_q[i], rdata);
        "R":
        begin
          bus_access(1'b0, adr_q[i], '0, rdata);
          exp_w.raw = exp_q[i];
          if (adr_q[i] == cop_pkg::ADDR_CTRL)
            exp_w.ctrl.spare = '0;                // Unused ctrl bits read as zero
          check_value("wb_dat_o", exp_w.raw, rdata);
        end
        "G":
        begin
          bus_access(1'b0, adr_q[i], '0, rdata);
          checks++;
          if (rdata > exp_q[i])                   // Running counter, upper bound only
          begin
            errors++;
            $display("ERROR at %0t: wb_dat_o expected <= %h, got %h", $time, exp_q[i], rdata);
          end
        end
        "I": repeat (dat_q[i]) @(negedge bus_clk);
        "O":
        begin
          check_value("cop_rst_o", exp_q[i][1], cop_rst_o);
          check_value("cop_irq_o", exp_q[i][0], cop_irq_o);
        end
        default:
        begin
          errors++;
          $display("Unknown opcode in pattern entry %0d", i);
        end
      endcase
    end

    errors += UUT.u_chk.assert_fails;             // Bound checker failures
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/cop_chk.sv */
/* Bound to cop_top and sees only its pins. Keeps its own copy of the service arming
   state, so it follows the bus the same way the register bank does. */

`timescale 1ns/1ps
`default_nettype none

module cop_chk (
  input  logic                        bus_clk,
  input  logic                        async_rst_b,
  input  logic                        wb_we_i,
  input  logic [cop_pkg::ADDR_W-1:0]  wb_adr_i,
  input  logic [cop_pkg::DATA_W-1:0]  wb_dat_i,
  input  logic [cop_pkg::DATA_W-1:0]  wb_dat_o,
  input  logic                        wb_ack_o,
  input  logic                        cop_rst_o,
  input  logic                        cop_irq_o
);

  logic serv_wr;      // Service write in its ack cycle
  logic armed;        // Last service word was SERV_WD_0
  logic good_serv;    // Completing word of a valid sequence
  int   assert_fails = 0;  // Failed assertion count

  assign serv_wr   = wb_ack_o && wb_we_i && (wb_adr_i == cop_pkg::ADDR_SERVICE);
  assign good_serv = serv_wr && armed && (wb_dat_i == cop_pkg::SERV_WD_1);

  always_ff @(posedge bus_clk or negedge async_rst_b)
    if (!async_rst_b)
      armed <= 1'b0;
    else if (serv_wr)
      armed <= (wb_dat_i == cop_pkg::SERV_WD_0);

  // Ack is a single cycle
  ack_single: assert property (@(posedge bus_clk) disable iff (!async_rst_b)
    wb_ack_o |=> !wb_ack_o)
    else
    begin
      assert_fails++;
      $error("wb_ack_o stayed high for two cycles");
    end

  // Reload pulse, then load, then reset output is low
  rst_cleared: assert property (@(posedge bus_clk) disable iff (!async_rst_b)
    good_serv |-> ##2 !cop_rst_o)
    else
    begin
      assert_fails++;
      $error("cop_rst_o still high after a valid service sequence");
    end

  outputs_in_reset: assert property (@(posedge bus_clk)
    !async_rst_b |-> (!wb_ack_o && !cop_rst_o && !cop_irq_o && (wb_dat_o == '0)))
    else
    begin
      assert_fails++;
      $error("An output is not low during reset");
    end

endmodule

bind cop_top cop_chk u_chk (
  .bus_clk     (bus_clk),
  .async_rst_b (async_rst_b),
  .wb_we_i     (wb_we_i),
  .wb_adr_i    (wb_adr_i),
  .wb_dat_i    (wb_dat_i),
  .wb_dat_o    (wb_dat_o),
  .wb_ack_o    (wb_ack_o),
  .cop_rst_o   (cop_rst_o),
  .cop_irq_o   (cop_irq_o)
);

`default_nettype wire

/* sim/cop_patterns.txt */
# op adr data mode exp, all hex; mode bits are debug,wait,stop; I idles data cycles
# O compares exp = {cop_rst_o,cop_irq_o}; G passes if the read is <= exp
R 0 0000 0 0004
R 1 0000 0 FFFF
O 0 0000 0 0
W 1 0100 0 0
R 1 0000 0 FFFF
W 0 0000 0 0
W 1 0100 0 0
R 1 0000 0 0100
R 2 0000 0 0100
W 0 0006 0 0
W 0 0002 0 0
R 0 0000 0 0006
W 0 0007 0 0
W 0 0005 0 0
R 0 0000 0 0007
W 0 0053 1 0
W 2 5555 1 0
W 2 AAAA 1 0
R 2 0000 1 0100
I 0 0005 1 0
R 2 0000 1 0100
W 2 5555 0 0
W 2 AAAA 0 0
G 2 0000 0 0100
W 2 5555 1 0
W 2 1234 1 0
G 2 0000 1 00FF
W 2 AAAA 1 0
G 2 0000 1 00FF
I 0 0120 0 0
O 0 0000 0 3
R 0 0000 0 0157
W 2 5555 0 0
W 2 AAAA 0 0
I 0 0003 0 0
O 0 0000 0 0
R 0 0000 0 0157
W 0 0153 0 0
R 0 0000 0 0057

/* verilog.f */
source/cop_pkg.sv
source/cop_ifs.sv
source/cop_bus_port.sv
source/cop_ctrl_regs.sv
source/cop_timer.sv
source/cop_top.sv
sim/cop_tb.sv
sim/cop_chk.sv
